//--- include/icache_params.svh
// ======================================================================
// Instruction cache geometry and bus widths
// Shared by the fetch and memory bus packages and all cache RTL
// ======================================================================
`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

// Byte address and instruction word
`define ICACHE_ADDR_WIDTH    26
`define ICACHE_DATA_WIDTH    32

// 64 lines of 4 words
`define ICACHE_INDEX_WIDTH   6
`define ICACHE_OFFSET_WIDTH  2

// Tag is what remains above index, offset and byte bits
`define ICACHE_TAG_WIDTH (`ICACHE_ADDR_WIDTH - `ICACHE_INDEX_WIDTH - `ICACHE_OFFSET_WIDTH - 2)

// AXI transaction id
`define AXI_ID_WIDTH         4

`endif

//--- hdl/fetch_types_pkg.sv
// ======================================================================
// Fetch side types
// Request from the core, response to the core, refill FSM states
// ======================================================================
`include "icache_params.svh"

package fetch_types_pkg;

    // Fetch address from the core
    typedef struct packed {
        logic                            valid;
        logic [`ICACHE_ADDR_WIDTH-1:0]   addr;
    } fetch_req_t;

    // Instruction back to the core
    typedef struct packed {
        logic                            valid;
        logic [`ICACHE_ADDR_WIDTH-1:0]   addr;
        logic [`ICACHE_DATA_WIDTH-1:0]   data;
    } fetch_resp_t;

    // Cache refill FSM
    typedef enum logic [1:0] {
        READY,
        // Burst issued, no beat written yet
        REFILL_REQUEST,
        // Beats arriving, then one re-read cycle
        REFILL_DATA
    } refill_state_e;

endpackage

//--- hdl/mem_bus_pkg.sv
// ======================================================================
// Memory side types
// AXI read address and read data channels of the line refill
// ======================================================================
`include "icache_params.svh"

package mem_bus_pkg;

    // Read address channel, master to memory
    typedef struct packed {
        logic                            arvalid;
        logic [`ICACHE_ADDR_WIDTH-1:0]   araddr;
        // Beats minus one
        logic [7:0]                      arlen;
        logic [`AXI_ID_WIDTH-1:0]        arid;
    } axi_ar_t;

    // Read data channel, memory to master
    typedef struct packed {
        logic                            rvalid;
        logic [`ICACHE_DATA_WIDTH-1:0]   rdata;
        logic                            rlast;
        logic [`AXI_ID_WIDTH-1:0]        rid;
    } axi_r_t;

endpackage

//--- hdl/cache_bank.sv
// ======================================================================
// Cache storage bank
// One write port, one registered read port, used for tags and words
// ======================================================================
`timescale 1ns/10ps

module cache_bank #(
    parameter int DATA_WIDTH = 32,
    parameter int ADDR_WIDTH = 6
) (
    input  logic                  clk,
    input  logic                  i_we,
    input  logic [ADDR_WIDTH-1:0] i_waddr,
    input  logic [DATA_WIDTH-1:0] i_wdata,
    input  logic [ADDR_WIDTH-1:0] i_raddr,
    output logic [DATA_WIDTH-1:0] o_rdata
);

    localparam int DEPTH = 1 << ADDR_WIDTH;

    // Storage array, no reset
    logic [DATA_WIDTH-1:0] mem [DEPTH];

    // Write and registered read on the same edge
    // A read of the address being written returns the old word
    always_ff @(posedge clk)
    begin
        if (i_we)
        begin
            mem[i_waddr] <= i_wdata;
        end
        o_rdata <= mem[i_raddr];
    end

endmodule

//--- hdl/fetch_pc_stage.sv
// ======================================================================
// Fetch address stage
// Registers the fetch request, holds it over a miss and selects the
// index the banks read on the coming edge
// ======================================================================
`timescale 1ns/10ps
`include "icache_params.svh"

module fetch_pc_stage (
    input  logic                              clk,
    input  logic                              rst_n,
    input  fetch_types_pkg::fetch_req_t       i_pc_next,
    input  logic                              i_hit,
    output fetch_types_pkg::fetch_req_t       o_req,
    output logic [`ICACHE_INDEX_WIDTH-1:0]    o_raddr_index
);

    // Index sits above word offset and byte bits
    localparam int IDX_LSB = `ICACHE_OFFSET_WIDTH + 2;

    logic                            req_valid;
    logic [`ICACHE_ADDR_WIDTH-1:0]   req_addr;
    logic                            load;

    // Take a new address when empty or when the current one completes
    assign load = !req_valid || i_hit;

    // Valid bit
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            req_valid <= 1'b0;
        end
        else if (load)
        begin
            req_valid <= i_pc_next.valid;
        end
    end

    // Address payload
    always_ff @(posedge clk)
    begin
        if (load)
        begin
            req_addr <= i_pc_next.addr;
        end
    end

    assign o_req = '{valid: req_valid, addr: req_addr};

    // Next index on load, else keep re-reading the current line
    // so a freshly refilled line shows up at the bank outputs
    always_comb
    begin
        if (load)
        begin
            o_raddr_index = i_pc_next.addr[IDX_LSB +: `ICACHE_INDEX_WIDTH];
        end
        else
        begin
            o_raddr_index = req_addr[IDX_LSB +: `ICACHE_INDEX_WIDTH];
        end
    end

    // Pending request stays put until the core sees it served
    a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        o_req.valid && !i_hit |=> $stable(o_req));

endmodule

//--- hdl/icache_core.sv
// ======================================================================
// Instruction cache core
// Direct-mapped tag and data banks, valid bits, hit detection and the
// refill FSM that hands misses to the refill master
// ======================================================================
`timescale 1ns/10ps
`include "icache_params.svh"

module icache_core (
    input  logic                                              clk,
    input  logic                                              rst_n,
    input  fetch_types_pkg::fetch_req_t                       i_req,
    input  logic [`ICACHE_INDEX_WIDTH-1:0]                    i_raddr_index,
    input  logic                                              i_word_we,
    input  logic [`ICACHE_OFFSET_WIDTH-1:0]                   i_word_sel,
    input  logic [`ICACHE_DATA_WIDTH-1:0]                     i_word_data,
    input  logic                                              i_last_word,
    output fetch_types_pkg::fetch_resp_t                      o_fetch,
    output logic                                              o_hit,
    output logic                                              o_refill_start,
    output logic [`ICACHE_TAG_WIDTH+`ICACHE_INDEX_WIDTH-1:0]  o_refill_addr
);

    import fetch_types_pkg::*;

    localparam int LINE_WORDS = 1 << `ICACHE_OFFSET_WIDTH;
    localparam int DEPTH      = 1 << `ICACHE_INDEX_WIDTH;

    // Fields of the registered address
    logic [`ICACHE_TAG_WIDTH-1:0]    req_tag;
    logic [`ICACHE_INDEX_WIDTH-1:0]  req_index;
    logic [`ICACHE_OFFSET_WIDTH-1:0] req_offset;

    assign {req_tag, req_index, req_offset} = i_req.addr[`ICACHE_ADDR_WIDTH-1:2];

    refill_state_e                   state;
    refill_state_e                   next_state;

    logic [DEPTH-1:0]                valid_bits;
    logic [`ICACHE_TAG_WIDTH-1:0]    tag_rdata;
    logic [`ICACHE_DATA_WIDTH-1:0]   word_rdata [LINE_WORDS];
    logic                            last_word_q;
    logic                            miss;

    // Tag bank, written with the final beat
    cache_bank #(
        .DATA_WIDTH (`ICACHE_TAG_WIDTH),
        .ADDR_WIDTH (`ICACHE_INDEX_WIDTH)
    ) tag_bank (
        .clk     (clk),
        .i_we    (i_last_word),
        .i_waddr (req_index),
        .i_wdata (req_tag),
        .i_raddr (i_raddr_index),
        .o_rdata (tag_rdata)
    );

    // One data bank per word of the line
    for (genvar w = 0; w < LINE_WORDS; w++)
    begin : g_word_bank
        cache_bank #(
            .DATA_WIDTH (`ICACHE_DATA_WIDTH),
            .ADDR_WIDTH (`ICACHE_INDEX_WIDTH)
        ) data_bank (
            .clk     (clk),
            .i_we    (i_word_we && (i_word_sel == w)),
            .i_waddr (req_index),
            .i_wdata (i_word_data),
            .i_raddr (i_raddr_index),
            .o_rdata (word_rdata[w])
        );
    end

    // Hit only when idle, bank outputs belong to the registered request
    assign o_hit = i_req.valid && (state == READY) && valid_bits[req_index]
        && (tag_rdata == req_tag);
    assign miss  = i_req.valid && (state == READY) && !o_hit;

    assign o_fetch = '{valid: o_hit, addr: i_req.addr, data: word_rdata[req_offset]};

    // Refill line address, request is held for the whole refill
    assign o_refill_start = miss;
    assign o_refill_addr  = {req_tag, req_index};

    // FSM next state
    always_comb
    begin
        next_state = state;
        case (state)
            READY:
                if (miss)
                    next_state = REFILL_REQUEST;
            REFILL_REQUEST:
                if (i_word_we)
                    next_state = REFILL_DATA;
            REFILL_DATA:
                // One extra cycle so the banks re-read the new line
                if (last_word_q)
                    next_state = READY;
            default:
                next_state = READY;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state       <= READY;
            last_word_q <= 1'b0;
            valid_bits  <= '0;
        end
        else
        begin
            state       <= next_state;
            last_word_q <= i_last_word;
            // Line goes invalid while being overwritten
            if (miss)
            begin
                valid_bits[req_index] <= 1'b0;
            end
            else if (i_last_word)
            begin
                valid_bits[req_index] <= 1'b1;
            end
        end
    end

    // Refill beats only land while a refill is open
    a_no_write_ready: assert property (@(posedge clk) disable iff (!rst_n)
        state == READY |-> !i_word_we);

endmodule

//--- hdl/refill_master.sv
// ======================================================================
// Line refill master
// Issues one AXI read burst per miss and turns the returning beats
// into word write strobes for the cache banks
// ======================================================================
`timescale 1ns/10ps
`include "icache_params.svh"

module refill_master (
    input  logic                                              clk,
    input  logic                                              rst_n,
    input  logic                                              i_start,
    input  logic [`ICACHE_TAG_WIDTH+`ICACHE_INDEX_WIDTH-1:0]  i_line_addr,
    input  logic                                              i_ar_ready,
    input  mem_bus_pkg::axi_r_t                               i_r,
    output mem_bus_pkg::axi_ar_t                              o_ar,
    output logic                                              o_r_ready,
    output logic                                              o_word_we,
    output logic [`ICACHE_OFFSET_WIDTH-1:0]                   o_word_sel,
    output logic [`ICACHE_DATA_WIDTH-1:0]                     o_word_data,
    output logic                                              o_last_word
);

    localparam int LINE_WORDS = 1 << `ICACHE_OFFSET_WIDTH;
    localparam logic [`AXI_ID_WIDTH-1:0] REFILL_ID = '0;

    logic [`ICACHE_TAG_WIDTH+`ICACHE_INDEX_WIDTH-1:0] line_addr_q;
    logic                                             ar_valid;
    logic                                             busy;
    logic [`ICACHE_OFFSET_WIDTH-1:0]                  beat_cnt;
    logic                                             beat;

    // Beat of our burst
    assign beat = busy && i_r.rvalid && (i_r.rid == REFILL_ID);

    // Line address, latched at start
    always_ff @(posedge clk)
    begin
        if (i_start)
        begin
            line_addr_q <= i_line_addr;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            ar_valid <= 1'b0;
            busy     <= 1'b0;
            beat_cnt <= '0;
        end
        else if (i_start)
        begin
            ar_valid <= 1'b1;
            busy     <= 1'b1;
            beat_cnt <= '0;
        end
        else
        begin
            // Address phase ends on handshake
            if (ar_valid && i_ar_ready)
            begin
                ar_valid <= 1'b0;
            end
            if (beat)
            begin
                beat_cnt <= beat_cnt + 1'b1;
                if (beat_cnt == `ICACHE_OFFSET_WIDTH'(LINE_WORDS - 1))
                begin
                    busy <= 1'b0;
                end
            end
        end
    end

    // Line-aligned address, full line burst
    assign o_ar = '{arvalid: ar_valid,
                    araddr:  {line_addr_q, {(`ICACHE_OFFSET_WIDTH + 2){1'b0}}},
                    arlen:   8'(LINE_WORDS - 1),
                    arid:    REFILL_ID};

    // Data always accepted
    assign o_r_ready = 1'b1;

    // Beats arrive in word order
    assign o_word_we   = beat;
    assign o_word_sel  = beat_cnt;
    assign o_word_data = i_r.rdata;
    assign o_last_word = beat && (beat_cnt == `ICACHE_OFFSET_WIDTH'(LINE_WORDS - 1));

    // Memory marks the final beat where the count expects it
    a_rlast_count: assert property (@(posedge clk) disable iff (!rst_n)
        beat |-> (i_r.rlast == (beat_cnt == `ICACHE_OFFSET_WIDTH'(LINE_WORDS - 1))));

    // Cache core waits for the previous refill before the next miss
    a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
        i_start |-> !busy);

endmodule

//--- hdl/icache_top.sv
// ======================================================================
// Instruction cache top level
// Fetch address stage, cache core and refill master between the core
// fetch port and the AXI read channels
// ======================================================================
`timescale 1ns/10ps
`include "icache_params.svh"

module icache_top (
    input  logic                             clk,
    input  logic                             rst_n,
    input  fetch_types_pkg::fetch_req_t      i_pc_next,
    output fetch_types_pkg::fetch_resp_t     o_fetch,
    output mem_bus_pkg::axi_ar_t             o_ar,
    input  logic                             i_ar_ready,
    input  mem_bus_pkg::axi_r_t              i_r,
    output logic                             o_r_ready
);

    import fetch_types_pkg::*;

    // Registered request and bank read index
    fetch_req_t                                        req;
    logic [`ICACHE_INDEX_WIDTH-1:0]                    raddr_index;
    logic                                              hit;

    // Refill handoff
    logic                                              refill_start;
    logic [`ICACHE_TAG_WIDTH+`ICACHE_INDEX_WIDTH-1:0]  refill_addr;
    logic                                              word_we;
    logic [`ICACHE_OFFSET_WIDTH-1:0]                   word_sel;
    logic [`ICACHE_DATA_WIDTH-1:0]                     word_data;
    logic                                              last_word;

    fetch_pc_stage u_pc_stage (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_pc_next     (i_pc_next),
        .i_hit         (hit),
        .o_req         (req),
        .o_raddr_index (raddr_index)
    );

    icache_core u_core (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_req          (req),
        .i_raddr_index  (raddr_index),
        .i_word_we      (word_we),
        .i_word_sel     (word_sel),
        .i_word_data    (word_data),
        .i_last_word    (last_word),
        .o_fetch        (o_fetch),
        .o_hit          (hit),
        .o_refill_start (refill_start),
        .o_refill_addr  (refill_addr)
    );

    refill_master u_refill (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_start     (refill_start),
        .i_line_addr (refill_addr),
        .i_ar_ready  (i_ar_ready),
        .i_r         (i_r),
        .o_ar        (o_ar),
        .o_r_ready   (o_r_ready),
        .o_word_we   (word_we),
        .o_word_sel  (word_sel),
        .o_word_data (word_data),
        .o_last_word (last_word)
    );

endmodule

//--- verification/axi_mem_model.sv
// ======================================================================
// AXI read memory model
// Answers one read burst at a time from a word image, with ARREADY
// delays and RVALID gaps taken from a random input word
// ======================================================================
`timescale 1ns/10ps
`include "icache_params.svh"

module axi_mem_model #(
    parameter int WORDS = 512
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  mem_bus_pkg::axi_ar_t    i_ar,
    output logic                    o_ar_ready,
    output mem_bus_pkg::axi_r_t     o_r,
    input  logic                    i_r_ready,
    input  logic [31:0]             i_stall_rand
);

    import mem_bus_pkg::*;

    localparam int WIDX = $clog2(WORDS);

    // Word image, loaded by the testbench
    logic [`ICACHE_DATA_WIDTH-1:0] mem [WORDS];

    logic                          busy;
    logic [WIDX-1:0]               base;
    logic [7:0]                    len;
    logic [7:0]                    beat;
    logic [`AXI_ID_WIDTH-1:0]      id;

    // Quiet bus before the first falling edge
    initial
    begin
        o_ar_ready = 1'b0;
        o_r        = '0;
    end

    // Address accept and beat count, as the DUT sees them
    always @(posedge clk)
    begin
        if (!rst_n)
        begin
            busy <= 1'b0;
            beat <= '0;
        end
        else if (!busy && i_ar.arvalid && o_ar_ready)
        begin
            busy <= 1'b1;
            base <= i_ar.araddr[WIDX+1:2];
            len  <= i_ar.arlen;
            id   <= i_ar.arid;
            beat <= '0;
        end
        else if (busy && o_r.rvalid && i_r_ready)
        begin
            beat <= beat + 8'd1;
            // Burst done after the last beat
            if (beat == len)
            begin
                busy <= 1'b0;
            end
        end
    end

    // Outputs change on the falling edge
    always @(negedge clk)
    begin
        if (!rst_n)
        begin
            o_ar_ready <= 1'b0;
            o_r        <= '0;
        end
        else
        begin
            // One burst outstanding, ready about one cycle in four
            o_ar_ready <= !busy && (i_stall_rand[1:0] == 2'b00);
            // Gap about one cycle in four
            if (busy && (i_stall_rand[3:2] != 2'b00))
            begin
                o_r <= '{rvalid: 1'b1,
                         rdata:  mem[base + WIDX'(beat)],
                         rlast:  (beat == len),
                         rid:    id};
            end
            else
            begin
                o_r <= '0;
            end
        end
    end

endmodule

//--- verification/icache_tb.sv
// ======================================================================
// Instruction cache testbench
// Replays the fetch sequence of the test data file against a stalling
// memory model, checks words, AR traffic and hit latency
// ======================================================================
`timescale 1ns/10ps
`include "icache_params.svh"

module icache_tb;

    import fetch_types_pkg::*;
    import mem_bus_pkg::*;

    // Test data holds the image words followed by the fetch count and addresses
    localparam int IMG_WORDS     = 512;
    localparam int SEQ_BASE      = 512;
    localparam int TD_WORDS      = 576;
    localparam int FETCH_TIMEOUT = 200;
    localparam int LINES         = 1 << `ICACHE_INDEX_WIDTH;
    localparam int IDX_LSB       = `ICACHE_OFFSET_WIDTH + 2;
    localparam int TAG_LSB       = IDX_LSB + `ICACHE_INDEX_WIDTH;

    logic                          clk;
    logic                          rst_n;
    fetch_req_t                    pc_next;
    fetch_resp_t                   fetch;
    axi_ar_t                       ar;
    logic                          ar_ready;
    axi_r_t                        r;
    logic                          r_ready;
    logic [31:0]                   stall_rand;

    logic [31:0]                   tdata [TD_WORDS];
    // Expected direct-mapped cache contents
    logic [`ICACHE_TAG_WIDTH-1:0]  shadow_tag [LINES];
    logic [LINES-1:0]              shadow_valid;

    // AR port bookkeeping
    int                            ar_count;
    logic [`ICACHE_ADDR_WIDTH-1:0] last_araddr;
    logic [7:0]                    last_arlen;
    logic                          ar_waiting;
    logic [`ICACHE_ADDR_WIDTH-1:0] wait_addr;
    logic [`AXI_ID_WIDTH-1:0]      wait_id;

    icache_top UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_pc_next  (pc_next),
        .o_fetch    (fetch),
        .o_ar       (ar),
        .i_ar_ready (ar_ready),
        .i_r        (r),
        .o_r_ready  (r_ready)
    );

    axi_mem_model #(
        .WORDS (IMG_WORDS)
    ) mem_model (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_ar         (ar),
        .o_ar_ready   (ar_ready),
        .o_r          (r),
        .i_r_ready    (r_ready),
        .i_stall_rand (stall_rand)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Stall source word renewed every rising edge
    initial
    begin
        stall_rand = '0;
        void'($urandom(32'h9293c609));
        forever
        begin
            @(posedge clk);
            stall_rand <= $urandom;
        end
    end

    task automatic flag_mismatch(input string test, input logic [31:0] expected,
                                 input logic [31:0] actual);
        $display("FAIL %s expected %h actual %h", test, expected, actual);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic stop_with_error(input string what);
        $display("ERROR %s", what);
        $display("Errors found");
        $fatal(1);
    endtask

    // Pattern over the whole array before the file goes on top
    task automatic load_testdata();
        for (int i = 0; i < TD_WORDS; i++)
        begin
            tdata[i] = {16'ha5a5 ^ i[15:0], i[15:0]};
        end
        $readmemh("verification/icache_testdata.txt", tdata);
        for (int i = 0; i < IMG_WORDS; i++)
        begin
            mem_model.mem[i] = tdata[i];
        end
    endtask

    task automatic check_idle_outputs(input string phase);
        assert (fetch.valid == 1'b0)
        else flag_mismatch({phase, "_fetch_valid"}, 32'd0, 32'(fetch.valid));
        assert (ar.arvalid == 1'b0)
        else flag_mismatch({phase, "_arvalid"}, 32'd0, 32'(ar.arvalid));
    endtask

    // One fetch held until the cache returns its address
    task automatic run_fetch(input int step, input logic [`ICACHE_ADDR_WIDTH-1:0] addr);
        logic [`ICACHE_INDEX_WIDTH-1:0]  idx;
        logic [`ICACHE_TAG_WIDTH-1:0]    tag;
        logic                            miss;
        logic [31:0]                     exp_word;
        int                              ar_before;
        int                              cycles;
        string                           name;
        idx      = addr[IDX_LSB +: `ICACHE_INDEX_WIDTH];
        tag      = addr[`ICACHE_ADDR_WIDTH-1:TAG_LSB];
        miss     = !shadow_valid[idx] || (shadow_tag[idx] != tag);
        name     = $sformatf("fetch%0d_%h", step, addr);
        assert (addr < IMG_WORDS * 4)
        else stop_with_error($sformatf("fetch address %h lies outside the image", addr));
        exp_word  = tdata[addr >> 2];
        ar_before = ar_count;
        pc_next   = '{valid: 1'b1, addr: addr};
        cycles    = 0;
        do
        begin
            @(negedge clk);
            cycles++;
        end
        while (!(fetch.valid && fetch.addr == addr) && cycles < FETCH_TIMEOUT);
        assert (fetch.valid && fetch.addr == addr)
        else stop_with_error($sformatf("no response to fetch of %h within %0d cycles",
                                       addr, FETCH_TIMEOUT));
        assert (fetch.data == exp_word)
        else flag_mismatch({name, "_data"}, exp_word, fetch.data);
        // One burst per miss and none on a hit
        assert (ar_count - ar_before == (miss ? 1 : 0))
        else flag_mismatch({name, "_reads"}, miss ? 32'd1 : 32'd0, 32'(ar_count - ar_before));
        if (miss)
        begin
            assert (last_araddr == {addr[`ICACHE_ADDR_WIDTH-1:IDX_LSB], {IDX_LSB{1'b0}}})
            else flag_mismatch({name, "_araddr"},
                               32'({addr[`ICACHE_ADDR_WIDTH-1:IDX_LSB], {IDX_LSB{1'b0}}}),
                               32'(last_araddr));
            assert (last_arlen == 8'd3)
            else flag_mismatch({name, "_arlen"}, 32'd3, 32'(last_arlen));
        end
        else
        begin
            // Hits stream at one per cycle
            assert (cycles == 1)
            else flag_mismatch({name, "_latency"}, 32'd1, 32'(cycles));
        end
        shadow_valid[idx] = 1'b1;
        shadow_tag[idx]   = tag;
    endtask

    // AR handshake count and address and id hold while ARVALID waits
    always @(posedge clk)
    begin
        if (rst_n)
        begin
            assert (r_ready) else stop_with_error("RREADY went low");
            if (ar_waiting)
            begin
                assert (ar.arvalid) else stop_with_error("ARVALID dropped before ARREADY");
                assert (ar.araddr == wait_addr)
                else flag_mismatch("ar_addr_stable", 32'(wait_addr), 32'(ar.araddr));
                assert (ar.arid == wait_id)
                else flag_mismatch("ar_id_stable", 32'(wait_id), 32'(ar.arid));
            end
            if (ar.arvalid && ar_ready)
            begin
                ar_count++;
                last_araddr = ar.araddr;
                last_arlen  = ar.arlen;
                ar_waiting  = 1'b0;
            end
            else
            begin
                ar_waiting = ar.arvalid;
                wait_addr  = ar.araddr;
                wait_id    = ar.arid;
            end
        end
    end

    initial
    begin : main
        int n_fetch;
        rst_n           = 1'b0;
        pc_next         = '0;
        shadow_valid    = '0;
        ar_count        = 0;
        ar_waiting      = 1'b0;
        last_araddr     = '0;
        last_arlen      = '0;
        wait_addr       = '0;
        wait_id         = '0;
        load_testdata();
        repeat (8)
        begin
            @(negedge clk);
            check_idle_outputs("reset");
        end
        rst_n = 1'b1;
        @(negedge clk);
        check_idle_outputs("after_reset");
        n_fetch = int'(tdata[SEQ_BASE]);
        assert (n_fetch > 0 && n_fetch < TD_WORDS - SEQ_BASE)
        else stop_with_error("fetch count in the test data is out of range");
        for (int k = 0; k < n_fetch; k++)
        begin
            run_fetch(k, tdata[SEQ_BASE + 1 + k][`ICACHE_ADDR_WIDTH-1:0]);
        end
        $display("No errors");
        $finish;
    end

endmodule

//--- verification/icache_testdata.txt
// Word-addressed hex image: @000 to @1ff memory words, four per line
// @200 fetch count, then byte addresses of the fetch sequence, four per line
// Line 0 and line 1, byte 0x000 to 0x01f
@000
3c1d0040 27bdfff0 afbf000c 0c000010
00000000 8fbf000c 27bd0010 03e00008
// Line at byte 0x400, same index as line 0
@100
24020005 24030007 00431020 1000ffff
// Fetch sequence
@200
00000014
// Cold misses, then hit streaming through lines 0 and 1
00000000 00000004 00000008 0000000c
00000010 00000014 00000018 0000001c
// Conflicts on index 0, line 1 still resident
00000400 00000404 00000000 00000400
00000008 0000040c 00000014 000007f0
// Index 63 from the pattern-filled image, then back to line 0
000007fc 000003f4 000007f8 00000004

//--- all.f
+incdir+include
hdl/fetch_types_pkg.sv
hdl/mem_bus_pkg.sv
hdl/cache_bank.sv
hdl/fetch_pc_stage.sv
hdl/icache_core.sv
hdl/refill_master.sv
hdl/icache_top.sv
verification/axi_mem_model.sv
verification/icache_tb.sv

//--- Makefile
# Verilator build and run of the instruction cache testbench

TOP := icache_tb

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): all.f include/icache_params.svh $(wildcard hdl/*.sv) $(wildcard verification/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f all.f

# Pass only when the log holds the pass message
run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -q "No errors" sim.log

clean:
	rm -rf obj_dir sim.log
